/* src/exu_pkg.sv */
package exu_pkg;

  parameter int unsigned XLEN = 64;
  parameter int unsigned WLEN = 32;

  typedef logic [XLEN-1:0] xlen_t;   // Operand or result
  typedef logic [WLEN-1:0] word_t;   // Low word for W ops
  typedef logic [6:0]      opcode_t;
  typedef logic [2:0]      funct3_t;
  typedef logic [3:0]      alu_op_t;

  // Major opcodes handled by the unit
  parameter opcode_t OPC_OP        = 7'b0110011;
  parameter opcode_t OPC_OP_IMM    = 7'b0010011;
  parameter opcode_t OPC_OP_32     = 7'b0111011;
  parameter opcode_t OPC_OP_IMM_32 = 7'b0011011;
  parameter opcode_t OPC_LUI       = 7'b0110111;
  parameter opcode_t OPC_AUIPC     = 7'b0010111;
  parameter opcode_t OPC_LOAD      = 7'b0000011;
  parameter opcode_t OPC_STORE     = 7'b0100011;

  // funct3 encodings of the integer group
  parameter funct3_t F3_ADD  = 3'b000;
  parameter funct3_t F3_SLL  = 3'b001;
  parameter funct3_t F3_SLT  = 3'b010;
  parameter funct3_t F3_SLTU = 3'b011;
  parameter funct3_t F3_XOR  = 3'b100;
  parameter funct3_t F3_SR   = 3'b101;   // srl or sra
  parameter funct3_t F3_OR   = 3'b110;
  parameter funct3_t F3_AND  = 3'b111;

  // ALU operations
  parameter alu_op_t ALU_ADD    = 4'd0;
  parameter alu_op_t ALU_SUB    = 4'd1;
  parameter alu_op_t ALU_SLL    = 4'd2;
  parameter alu_op_t ALU_SRL    = 4'd3;
  parameter alu_op_t ALU_SRA    = 4'd4;
  parameter alu_op_t ALU_SLT    = 4'd5;
  parameter alu_op_t ALU_SLTU   = 4'd6;
  parameter alu_op_t ALU_XOR    = 4'd7;
  parameter alu_op_t ALU_OR     = 4'd8;
  parameter alu_op_t ALU_AND    = 4'd9;
  parameter alu_op_t ALU_PASS_B = 4'd10;   // lui

endpackage

/* src/exu_issue.sv */
`timescale 1ns/1ps

module exu_issue (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  exu_pkg::opcode_t  opcode,
  input  exu_pkg::funct3_t  funct3,
  input  logic              funct7_5,
  input  exu_pkg::xlen_t    src1,
  input  exu_pkg::xlen_t    src2,
  input  exu_pkg::xlen_t    pc,
  output logic              op_valid,
  output exu_pkg::alu_op_t  alu_op,
  output logic              word_mode,
  output logic              illegal,
  output exu_pkg::xlen_t    a_opnd,
  output exu_pkg::xlen_t    b_opnd
);

  exu_pkg::alu_op_t dec_op;
  logic             dec_word;
  logic             dec_illegal;
  logic             dec_use_pc;
  logic             is_reg;

  // Decode of the major opcode and function fields
  always_comb begin
    dec_op      = exu_pkg::ALU_ADD;
    dec_word    = 1'b0;
    dec_illegal = 1'b0;
    dec_use_pc  = 1'b0;
    is_reg      = (opcode == exu_pkg::OPC_OP) || (opcode == exu_pkg::OPC_OP_32);
    case (opcode)
      exu_pkg::OPC_OP, exu_pkg::OPC_OP_IMM: begin
        case (funct3)
          exu_pkg::F3_ADD:  dec_op = (is_reg && funct7_5) ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
          exu_pkg::F3_SLL:  dec_op = exu_pkg::ALU_SLL;
          exu_pkg::F3_SLT:  dec_op = exu_pkg::ALU_SLT;
          exu_pkg::F3_SLTU: dec_op = exu_pkg::ALU_SLTU;
          exu_pkg::F3_XOR:  dec_op = exu_pkg::ALU_XOR;
          exu_pkg::F3_SR:   dec_op = funct7_5 ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
          exu_pkg::F3_OR:   dec_op = exu_pkg::ALU_OR;
          default:          dec_op = exu_pkg::ALU_AND;
        endcase
      end
      exu_pkg::OPC_OP_32, exu_pkg::OPC_OP_IMM_32: begin
        dec_word = 1'b1;
        case (funct3)
          exu_pkg::F3_ADD: dec_op = (is_reg && funct7_5) ? exu_pkg::ALU_SUB : exu_pkg::ALU_ADD;
          exu_pkg::F3_SLL: dec_op = exu_pkg::ALU_SLL;
          exu_pkg::F3_SR:  dec_op = funct7_5 ? exu_pkg::ALU_SRA : exu_pkg::ALU_SRL;
          default:         dec_illegal = 1'b1;   // No W form
        endcase
      end
      exu_pkg::OPC_LUI: begin
        dec_op = exu_pkg::ALU_PASS_B;
      end
      exu_pkg::OPC_AUIPC: begin
        dec_use_pc = 1'b1;
      end
      exu_pkg::OPC_LOAD, exu_pkg::OPC_STORE: begin
        dec_op = exu_pkg::ALU_ADD;   // Address add
      end
      default: begin
        dec_illegal = 1'b1;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op_valid  <= 1'b0;
      alu_op    <= exu_pkg::ALU_ADD;
      word_mode <= 1'b0;
      illegal   <= 1'b0;
    end else begin
      op_valid <= in_valid;
      if (in_valid) begin
        alu_op    <= dec_op;
        word_mode <= dec_word;
        illegal   <= dec_illegal;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid) begin
      a_opnd <= dec_use_pc ? pc : src1;
      b_opnd <= src2;
    end
  end

endmodule

/* src/exu_alu.sv */
`timescale 1ns/1ps

module exu_alu (
  input  exu_pkg::alu_op_t  alu_op,
  input  logic              word_mode,
  input  exu_pkg::xlen_t    a_opnd,
  input  exu_pkg::xlen_t    b_opnd,
  output exu_pkg::xlen_t    alu_res
);

  exu_pkg::word_t a_lo;
  exu_pkg::xlen_t a_shift;   // Shift source after word handling
  logic [5:0]     shamt;
  exu_pkg::xlen_t sum;
  exu_pkg::xlen_t diff;
  logic           lt_s;
  logic           lt_u;

  assign a_lo = a_opnd[exu_pkg::WLEN-1:0];

  // W shifts only see the low word and a 5-bit amount
  always_comb begin
    if (word_mode) begin
      shamt = {1'b0, b_opnd[4:0]};
      if (alu_op == exu_pkg::ALU_SRA) begin
        a_shift = {{(exu_pkg::XLEN-exu_pkg::WLEN){a_lo[exu_pkg::WLEN-1]}}, a_lo};
      end else begin
        a_shift = {{(exu_pkg::XLEN-exu_pkg::WLEN){1'b0}}, a_lo};
      end
    end else begin
      shamt   = b_opnd[5:0];
      a_shift = a_opnd;
    end
  end

  assign sum  = a_opnd + b_opnd;
  assign diff = a_opnd - b_opnd;
  assign lt_s = $signed(a_opnd) < $signed(b_opnd);
  assign lt_u = a_opnd < b_opnd;

  always_comb begin
    case (alu_op)
      exu_pkg::ALU_ADD:    alu_res = sum;
      exu_pkg::ALU_SUB:    alu_res = diff;
      exu_pkg::ALU_SLL:    alu_res = a_shift << shamt;
      exu_pkg::ALU_SRL:    alu_res = a_shift >> shamt;
      exu_pkg::ALU_SRA:    alu_res = exu_pkg::xlen_t'($signed(a_shift) >>> shamt);
      exu_pkg::ALU_SLT:    alu_res = {{(exu_pkg::XLEN-1){1'b0}}, lt_s};
      exu_pkg::ALU_SLTU:   alu_res = {{(exu_pkg::XLEN-1){1'b0}}, lt_u};
      exu_pkg::ALU_XOR:    alu_res = a_opnd ^ b_opnd;
      exu_pkg::ALU_OR:     alu_res = a_opnd | b_opnd;
      exu_pkg::ALU_AND:    alu_res = a_opnd & b_opnd;
      exu_pkg::ALU_PASS_B: alu_res = b_opnd;
      default:             alu_res = '0;
    endcase
  end

endmodule

/* src/exu_retire.sv */
`timescale 1ns/1ps

module exu_retire (
  input  logic            clk,
  input  logic            arst_n,
  input  logic            op_valid,
  input  logic            word_mode,
  input  logic            illegal,
  input  exu_pkg::xlen_t  alu_res,
  output logic            out_valid,
  output logic            out_illegal,
  output exu_pkg::xlen_t  result
);

  exu_pkg::word_t res_lo;
  exu_pkg::xlen_t res_final;

  assign res_lo = alu_res[exu_pkg::WLEN-1:0];

  always_comb begin
    if (illegal) begin
      res_final = '0;
    end else if (word_mode) begin
      res_final = {{(exu_pkg::XLEN-exu_pkg::WLEN){res_lo[exu_pkg::WLEN-1]}}, res_lo};
    end else begin
      res_final = alu_res;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid   <= 1'b0;
      out_illegal <= 1'b0;
      result      <= '0;
    end else begin
      out_valid <= op_valid;   // One pulse per op
      if (op_valid) begin
        out_illegal <= illegal;
        result      <= res_final;
      end
    end
  end

endmodule

/* src/exu_top.sv */
`timescale 1ns/1ps

module exu_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              in_valid,
  input  exu_pkg::opcode_t  opcode,
  input  exu_pkg::funct3_t  funct3,
  input  logic              funct7_5,
  input  exu_pkg::xlen_t    src1,
  input  exu_pkg::xlen_t    src2,
  input  exu_pkg::xlen_t    pc,
  output logic              out_valid,
  output logic              out_illegal,
  output exu_pkg::xlen_t    result
);

  logic             op_valid;
  exu_pkg::alu_op_t alu_op;
  logic             word_mode;
  logic             illegal;
  exu_pkg::xlen_t   a_opnd;
  exu_pkg::xlen_t   b_opnd;
  exu_pkg::xlen_t   alu_res;

  exu_issue u_issue (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (in_valid),
    .opcode    (opcode),
    .funct3    (funct3),
    .funct7_5  (funct7_5),
    .src1      (src1),
    .src2      (src2),
    .pc        (pc),
    .op_valid  (op_valid),
    .alu_op    (alu_op),
    .word_mode (word_mode),
    .illegal   (illegal),
    .a_opnd    (a_opnd),
    .b_opnd    (b_opnd)
  );

  exu_alu u_alu (
    .alu_op    (alu_op),
    .word_mode (word_mode),
    .a_opnd    (a_opnd),
    .b_opnd    (b_opnd),
    .alu_res   (alu_res)
  );

  exu_retire u_retire (
    .clk         (clk),
    .arst_n      (arst_n),
    .op_valid    (op_valid),
    .word_mode   (word_mode),
    .illegal     (illegal),
    .alu_res     (alu_res),
    .out_valid   (out_valid),
    .out_illegal (out_illegal),
    .result      (result)
  );

endmodule

/* test/exu_properties.sv */
`timescale 1ns/1ps

module exu_properties (
  input logic           clk,
  input logic           arst_n,
  input logic           in_valid,
  input logic           out_valid,
  input logic           out_illegal,
  input exu_pkg::xlen_t result
);

  // Fixed two-cycle latency, both ways
  a_latency: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> ##2 out_valid)
    else $error("out_valid missing two cycles after in_valid");

  a_no_spurious: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> $past(in_valid, 2))
    else $error("out_valid without in_valid two cycles earlier");

  a_illegal_zero: assert property (@(posedge clk) disable iff (!arst_n)
    (out_valid && out_illegal) |-> (result == '0))
    else $error("illegal result is not zero");

  a_reset_release: assert property (@(posedge clk)
    $rose(arst_n) |-> (!out_valid && result == '0))
    else $error("outputs not idle after reset");

endmodule

bind exu_top exu_properties u_props (
  .clk         (clk),
  .arst_n      (arst_n),
  .in_valid    (in_valid),
  .out_valid   (out_valid),
  .out_illegal (out_illegal),
  .result      (result)
);

/* test/tb_exu.sv */
`timescale 1ns/1ps

module tb_exu;

  logic             clk;
  logic             arst_n;
  logic             in_valid;
  exu_pkg::opcode_t opcode;
  exu_pkg::funct3_t funct3;
  logic             funct7_5;
  exu_pkg::xlen_t   src1;
  exu_pkg::xlen_t   src2;
  exu_pkg::xlen_t   pc;
  logic             out_valid;
  logic             out_illegal;
  exu_pkg::xlen_t   result;

  logic [31:0]      lcg_state;
  exu_pkg::xlen_t   exp_res_q[$];
  logic             exp_ill_q[$];
  int               exp_edge_q[$];   // Edge that sampled in_valid
  exu_pkg::xlen_t   exp_res;
  logic             exp_ill;
  int               exp_edge;
  int               cycle_cnt = 0;
  int               check_cnt = 0;
  int               err_cnt = 0;
  int               test_cnt = 0;
  int               chk_mark = 0;
  int               err_mark = 0;
  exu_pkg::opcode_t bad_opc[4] = '{7'h7f, 7'b1100011, 7'h00, 7'b1110011};

  exu_top u_dut (
    .clk         (clk),
    .arst_n      (arst_n),
    .in_valid    (in_valid),
    .opcode      (opcode),
    .funct3      (funct3),
    .funct7_5    (funct7_5),
    .src1        (src1),
    .src2        (src2),
    .pc          (pc),
    .out_valid   (out_valid),
    .out_illegal (out_illegal),
    .result      (result)
  );

  always #20 clk = ~clk;

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  function logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function exu_pkg::xlen_t rand64();
    exu_pkg::xlen_t v;
    v[63:32] = lcg_next();
    v[31:0]  = lcg_next();
    return v;
  endfunction

  function exu_pkg::xlen_t edge_opnd(input int k);
    case (k)
      0:       return 64'h7fff_ffff_ffff_ffff;
      1:       return 64'h8000_0000_0000_0000;
      2:       return 64'hffff_ffff_ffff_ffff;
      3:       return 64'h0;
      default: return 64'h1;
    endcase
  endfunction

  function exu_pkg::opcode_t pick_opcode(input int idx);
    case (idx)
      0:       return exu_pkg::OPC_OP;
      1:       return exu_pkg::OPC_OP_IMM;
      2:       return exu_pkg::OPC_OP_32;
      3:       return exu_pkg::OPC_OP_IMM_32;
      4:       return exu_pkg::OPC_LUI;
      5:       return exu_pkg::OPC_AUIPC;
      6:       return exu_pkg::OPC_LOAD;
      7:       return exu_pkg::OPC_STORE;
      default: return 7'b1100011;   // Branch, not handled here
    endcase
  endfunction

  // Expected result straight from the RV64I definitions
  function automatic exu_pkg::xlen_t ref_exu(input exu_pkg::opcode_t opc,
      input exu_pkg::funct3_t f3, input logic f7, input exu_pkg::xlen_t s1,
      input exu_pkg::xlen_t s2, input exu_pkg::xlen_t p, output logic ill);
    exu_pkg::xlen_t r;
    exu_pkg::word_t w;
    r   = '0;
    w   = '0;
    ill = 1'b0;
    if (opc == exu_pkg::OPC_OP || opc == exu_pkg::OPC_OP_IMM) begin
      case (f3)
        3'd0: r = (opc == exu_pkg::OPC_OP && f7) ? s1 - s2 : s1 + s2;
        3'd1: r = s1 << s2[5:0];
        3'd2: r = ($signed(s1) < $signed(s2)) ? 64'd1 : 64'd0;
        3'd3: r = (s1 < s2) ? 64'd1 : 64'd0;
        3'd4: r = s1 ^ s2;
        3'd5: begin
          if (f7) r = $signed(s1) >>> s2[5:0];
          else r = s1 >> s2[5:0];
        end
        3'd6: r = s1 | s2;
        default: r = s1 & s2;
      endcase
    end else if (opc == exu_pkg::OPC_OP_32 || opc == exu_pkg::OPC_OP_IMM_32) begin
      case (f3)
        3'd0: w = (opc == exu_pkg::OPC_OP_32 && f7) ? s1[31:0] - s2[31:0]
                                                    : s1[31:0] + s2[31:0];
        3'd1: w = s1[31:0] << s2[4:0];
        3'd5: begin
          if (f7) w = $signed(s1[31:0]) >>> s2[4:0];
          else w = s1[31:0] >> s2[4:0];
        end
        default: ill = 1'b1;
      endcase
      r = {{32{w[31]}}, w};
    end else if (opc == exu_pkg::OPC_LUI) begin
      r = s2;
    end else if (opc == exu_pkg::OPC_AUIPC) begin
      r = p + s2;
    end else if (opc == exu_pkg::OPC_LOAD || opc == exu_pkg::OPC_STORE) begin
      r = s1 + s2;
    end else begin
      ill = 1'b1;
    end
    if (ill) r = '0;
    return r;
  endfunction

  task automatic issue(input exu_pkg::opcode_t opc, input exu_pkg::funct3_t f3,
      input logic f7, input exu_pkg::xlen_t s1, input exu_pkg::xlen_t s2,
      input exu_pkg::xlen_t p);
    logic           ill;
    exu_pkg::xlen_t r;
    r = ref_exu(opc, f3, f7, s1, s2, p, ill);
    exp_res_q.push_back(r);
    exp_ill_q.push_back(ill);
    exp_edge_q.push_back(cycle_cnt + 1);
    in_valid = 1'b1;
    opcode   = opc;
    funct3   = f3;
    funct7_5 = f7;
    src1     = s1;
    src2     = s2;
    pc       = p;
    @(posedge clk);
    #2;
  endtask

  task automatic finish_test(input string name);
    int waited;
    in_valid = 1'b0;
    waited   = 0;
    while (exp_res_q.size() != 0 && waited < 16) begin
      @(posedge clk);
      #2;
      waited++;
    end
    if (exp_res_q.size() != 0) begin
      $display("%0t: %s timed out, %0d results never came out", $time, name,
               exp_res_q.size());
      $display("Test failed");
      $finish;
    end else begin
      test_cnt++;
      $display("%s: %0d checks, %0d errors", name, check_cnt - chk_mark, err_cnt - err_mark);
      chk_mark = check_cnt;
      err_mark = err_cnt;
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (arst_n && out_valid) begin
      check_cnt++;
      assert (exp_res_q.size() != 0) else begin
        $display("%0t: out_valid pulsed with no instruction in flight", $time);
        err_cnt++;
      end
      if (exp_res_q.size() != 0) begin
        exp_res  = exp_res_q.pop_front();
        exp_ill  = exp_ill_q.pop_front();
        exp_edge = exp_edge_q.pop_front();
        assert (out_illegal === exp_ill) else begin
          $display("mismatch at %0t: out_illegal got %b expected %b", $time, out_illegal,
                   exp_ill);
          err_cnt++;
        end
        assert (result === exp_res) else begin
          $display("mismatch at %0t: result got %h expected %h", $time, result, exp_res);
          err_cnt++;
        end
        // Next rising edge is the one that samples out_valid
        assert (cycle_cnt + 1 - exp_edge == 2) else begin
          $display("mismatch at %0t: out_valid latency got %0d expected 2", $time,
                   cycle_cnt + 1 - exp_edge);
          err_cnt++;
        end
      end
    end
  end

  initial begin
    exu_pkg::xlen_t s1v;
    exu_pkg::xlen_t s2v;
    logic [31:0]    r32;
    exu_pkg::opcode_t opc;
    clk       = 1'b0;
    arst_n    = 1'b0;
    in_valid  = 1'b0;
    opcode    = '0;
    funct3    = '0;
    funct7_5  = 1'b0;
    src1      = '0;
    src2      = '0;
    pc        = '0;
    lcg_state = 32'h329;
    repeat (8) @(posedge clk);
    #2;
    arst_n = 1'b1;

    for (int f = 0; f < 16; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue(exu_pkg::OPC_OP, f[2:0], f[3], edge_opnd(i), edge_opnd(j), '0);
        end
      end
      repeat (4) issue(exu_pkg::OPC_OP, f[2:0], f[3], rand64(), rand64(), '0);
    end
    finish_test("register arithmetic and logic");

    for (int m = 0; m < 2; m++) begin
      opc = m ? exu_pkg::OPC_OP_IMM : exu_pkg::OPC_OP;
      for (int sh = 0; sh < 64; sh++) begin
        s1v = rand64();
        s2v = rand64();
        s2v[5:0] = sh;   // Upper bits must be ignored
        issue(opc, exu_pkg::F3_SLL, 1'b0, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_SR, 1'b0, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_SR, 1'b1, s1v, s2v, '0);
      end
    end
    finish_test("shifts");

    for (int m = 0; m < 2; m++) begin
      opc = m ? exu_pkg::OPC_OP_IMM_32 : exu_pkg::OPC_OP_32;
      for (int sh = 0; sh < 32; sh++) begin
        s1v = rand64();
        s2v = rand64();
        s2v[4:0] = sh;
        issue(opc, exu_pkg::F3_ADD, 1'b0, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_ADD, 1'b1, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_SLL, 1'b0, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_SR, 1'b0, s1v, s2v, '0);
        issue(opc, exu_pkg::F3_SR, 1'b1, s1v, s2v, '0);
      end
    end
    finish_test("word operations");

    for (int k = 0; k < 16; k++) begin
      r32 = lcg_next();
      issue(exu_pkg::OPC_LUI, r32[2:0], r32[3], rand64(), rand64(), rand64());
      issue(exu_pkg::OPC_AUIPC, r32[6:4], r32[7], rand64(), rand64(), rand64());
      issue(exu_pkg::OPC_LOAD, r32[10:8], r32[11], rand64(), rand64(), rand64());
      issue(exu_pkg::OPC_STORE, r32[14:12], r32[15], rand64(), rand64(), rand64());
    end
    finish_test("lui auipc load store");

    foreach (bad_opc[i]) begin
      issue(bad_opc[i], 3'd0, 1'b0, rand64(), rand64(), rand64());
    end
    for (int f = 2; f < 8; f++) begin
      if (f != 5) begin   // srlw and sraw are legal
        issue(exu_pkg::OPC_OP_32, f[2:0], 1'b0, rand64(), rand64(), '0);
        issue(exu_pkg::OPC_OP_IMM_32, f[2:0], 1'b1, rand64(), rand64(), '0);
      end
    end
    finish_test("illegal encodings");

    for (int k = 0; k < 300; k++) begin
      r32 = lcg_next();
      issue(pick_opcode(r32[11:4] % 9), r32[2:0], r32[3], rand64(), rand64(), rand64());
    end
    finish_test("back-to-back issue");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* filelist.f */
src/exu_pkg.sv
src/exu_issue.sv
src/exu_alu.sv
src/exu_retire.sv
src/exu_top.sv
test/exu_properties.sv
test/tb_exu.sv

/* Bender.yml */
package:
  name: exu

sources:
  - files:
      - src/exu_pkg.sv
      - src/exu_issue.sv
      - src/exu_alu.sv
      - src/exu_retire.sv
      - src/exu_top.sv
  - target: test
    files:
      - test/exu_properties.sv
      - test/tb_exu.sv
